//--- src.f
source/dm_pkg.sv
source/dmi_req_capture.sv
source/dm_regs.sv
source/sys_sram.sv
source/dmi_resp_buffer.sv
source/dm_subsys_top.sv
tests/dm_subsys_sva.sv
tests/tb_dm_subsys.sv

//--- Makefile
SIM  := obj_dir/Vtb_dm_subsys
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) src.f
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_dm_subsys -o Vtb_dm_subsys

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tests/tb_dm_subsys.sv
// ----------------------------------------------------------------------
// Table-driven testbench for the debug subsystem: request driver,
// reference model, response checker and random response back-pressure
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_dm_subsys
    import dm_pkg::*;
();

    localparam int unsigned MEM_WORDS = 64;
    localparam int unsigned MAX_WAIT  = 100;

    typedef struct {
        string       name;
        dmi_op_e     op;
        logic [6:0]  addr;
        logic [31:0] data;
        logic        bp;
        dmi_resp_e   exp_code;
        logic [31:0] exp_data;
        logic        exp_dbg;
        logic        exp_ndm;
    } entry_t;

    logic                  clk_i;
    logic                  ndmreset_n;
    logic                  dmi_req_valid_i;
    logic                  dmi_req_ready_o;
    logic [DMI_ADDR_W-1:0] dmi_req_addr_i;
    dmi_op_e               dmi_req_op_i;
    logic [31:0]           dmi_req_data_i;
    logic                  dmi_resp_valid_o;
    logic                  dmi_resp_ready_i;
    dmi_resp_e             dmi_resp_code_o;
    logic [31:0]           dmi_resp_data_o;
    logic                  debug_req_o;
    logic                  ndmreset_o;

    entry_t      tbl[$];
    int          exp_q[$];
    logic [31:0] rng_state;
    logic        bp_en;
    logic        build_bp;
    logic        abort;
    int          received;
    int          err_value;
    int          err_timeout;
    int          err_protocol;

    // Reference model state
    logic [31:0]                  m_data0;
    logic [$clog2(MEM_WORDS)-1:0] m_sbaddr;
    logic                         m_haltreq;
    logic                         m_ndmreset;
    logic                         m_dmactive;
    logic [31:0]                  m_mem [MEM_WORDS];

    dm_subsys_top #(
        .NUM_WORDS ( MEM_WORDS )
    ) i_dut (
        .clk_i            ( clk_i            ),
        .ndmreset_n       ( ndmreset_n       ),
        .dmi_req_valid_i  ( dmi_req_valid_i  ),
        .dmi_req_ready_o  ( dmi_req_ready_o  ),
        .dmi_req_addr_i   ( dmi_req_addr_i   ),
        .dmi_req_op_i     ( dmi_req_op_i     ),
        .dmi_req_data_i   ( dmi_req_data_i   ),
        .dmi_resp_valid_o ( dmi_resp_valid_o ),
        .dmi_resp_ready_i ( dmi_resp_ready_i ),
        .dmi_resp_code_o  ( dmi_resp_code_o  ),
        .dmi_resp_data_o  ( dmi_resp_data_o  ),
        .debug_req_o      ( debug_req_o      ),
        .ndmreset_o       ( ndmreset_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic add_entry(input string name, input dmi_op_e op, input logic [6:0] addr,
                             input logic [31:0] data);
        entry_t e;
        e.name     = name;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.bp       = build_bp;
        e.exp_code = DMI_SUCCESS;
        e.exp_data = '0;
        e.exp_dbg  = 1'b0;
        e.exp_ndm  = 1'b0;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        build_bp = 1'b0;
        add_entry("dmcontrol_reset_rd", DMI_READ, ADDR_DMCONTROL, 32'h0);
        add_entry("data0_wr", DMI_WRITE, ADDR_DATA0, rand_word());
        add_entry("data0_rd", DMI_READ, ADDR_DATA0, 32'h0);
        add_entry("nop", DMI_NOP, ADDR_DATA0, rand_word());
        add_entry("dmcontrol_wr_inactive", DMI_WRITE, ADDR_DMCONTROL, 32'h8000_0002);
        add_entry("dmcontrol_rd_inactive", DMI_READ, ADDR_DMCONTROL, 32'h0);
        add_entry("dmcontrol_wr_active", DMI_WRITE, ADDR_DMCONTROL, 32'hFFFF_FFFF);
        add_entry("dmcontrol_rd_active", DMI_READ, ADDR_DMCONTROL, 32'h0);
        add_entry("dmcontrol_wr_clear", DMI_WRITE, ADDR_DMCONTROL, 32'h0);
        add_entry("dmcontrol_rd_clear", DMI_READ, ADDR_DMCONTROL, 32'h0);
        // Start near the top so the burst wraps past word 63
        add_entry("sbaddress_wr", DMI_WRITE, ADDR_SBADDRESS0, 32'hABCD_007C);
        for (int k = 0; k < 8; k++) begin
            add_entry($sformatf("sbdata_wr%0d", k), DMI_WRITE, ADDR_SBDATA0, rand_word());
        end
        add_entry("sbaddress_rewr", DMI_WRITE, ADDR_SBADDRESS0, 32'h0000_003C);
        for (int k = 0; k < 8; k++) begin
            add_entry($sformatf("sbdata_rd%0d", k), DMI_READ, ADDR_SBDATA0, 32'h0);
        end
        add_entry("sbaddress_rd", DMI_READ, ADDR_SBADDRESS0, 32'h0);
        add_entry("unknown_rd", DMI_READ, 7'h7F, 32'h0);
        add_entry("unknown_wr", DMI_WRITE, 7'h7F, rand_word());
        add_entry("data0_after_unknown", DMI_READ, ADDR_DATA0, 32'h0);
        add_entry("dmcontrol_after_unknown", DMI_READ, ADDR_DMCONTROL, 32'h0);
        add_entry("sbaddress_after_unknown", DMI_READ, ADDR_SBADDRESS0, 32'h0);
        // ------------------------------------------------------------------
        // Back-to-back traffic under random response back-pressure
        // ------------------------------------------------------------------
        build_bp = 1'b1;
        add_entry("bp_dmcontrol_wr", DMI_WRITE, ADDR_DMCONTROL, 32'h8000_0001);
        add_entry("bp_sbaddress_wr", DMI_WRITE, ADDR_SBADDRESS0, 32'h0000_003C);
        for (int k = 0; k < 6; k++) begin
            add_entry($sformatf("bp_data0_wr%0d", k), DMI_WRITE, ADDR_DATA0, rand_word());
            add_entry($sformatf("bp_sbdata_rd%0d", k), DMI_READ, ADDR_SBDATA0, 32'h0);
            add_entry($sformatf("bp_data0_rd%0d", k), DMI_READ, ADDR_DATA0, 32'h0);
        end
        add_entry("bp_dmcontrol_rd", DMI_READ, ADDR_DMCONTROL, 32'h0);
        add_entry("bp_nop", DMI_NOP, 7'h7F, rand_word());
    endtask

    // Walk the table in order and fill in the expected responses
    task automatic compute_expected();
        entry_t e;
        m_data0    = '0;
        m_sbaddr   = '0;
        m_haltreq  = 1'b0;
        m_ndmreset = 1'b0;
        m_dmactive = 1'b0;
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            if (e.op != DMI_NOP) begin
                case (e.addr)
                    ADDR_DATA0: begin
                        if (e.op == DMI_WRITE) m_data0 = e.data;
                        else e.exp_data = m_data0;
                    end
                    ADDR_DMCONTROL: begin
                        if (e.op == DMI_WRITE) begin
                            if (m_dmactive || e.data[0]) begin
                                m_dmactive = e.data[0];
                                m_haltreq  = e.data[31] & e.data[0];
                                m_ndmreset = e.data[1] & e.data[0];
                            end
                        end else begin
                            e.exp_data = {m_haltreq, 29'b0, m_ndmreset, m_dmactive};
                        end
                    end
                    ADDR_SBADDRESS0: begin
                        if (e.op == DMI_WRITE) m_sbaddr = e.data[$clog2(MEM_WORDS)-1:0];
                        else e.exp_data = 32'(m_sbaddr);
                    end
                    ADDR_SBDATA0: begin
                        if (e.op == DMI_WRITE) m_mem[m_sbaddr] = e.data;
                        else e.exp_data = m_mem[m_sbaddr];
                        // Word address wraps modulo the memory depth
                        m_sbaddr++;
                    end
                    default: e.exp_code = DMI_FAILED;
                endcase
            end
            e.exp_dbg = m_haltreq & m_dmactive;
            e.exp_ndm = m_ndmreset & m_dmactive;
            tbl[i] = e;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            err_value++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Returns in the time step of the rising edge that completes the handshake
    task automatic drive_request(input int idx);
        int waits;
        waits = 0;
        dmi_req_valid_i <= 1'b1;
        dmi_req_addr_i  <= tbl[idx].addr;
        dmi_req_op_i    <= tbl[idx].op;
        dmi_req_data_i  <= tbl[idx].data;
        @(negedge clk_i);
        while (!dmi_req_ready_o && waits < MAX_WAIT) begin
            @(negedge clk_i);
            waits++;
        end
        if (!dmi_req_ready_o) begin
            $display("Timeout: request %s was not accepted within %0d cycles",
                     tbl[idx].name, MAX_WAIT);
            err_timeout++;
            abort = 1'b1;
        end
        @(posedge clk_i);
    endtask

    task automatic wait_responses();
        int waits;
        waits = 0;
        while (received < tbl.size() && waits < MAX_WAIT) begin
            @(posedge clk_i);
            waits++;
        end
        if (received < tbl.size()) begin
            $display("Timeout: only %0d of %0d responses arrived", received, tbl.size());
            err_timeout++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: value %0d, timeout %0d, protocol %0d",
                 err_value, err_timeout, err_protocol);
        if (err_value + err_timeout + err_protocol == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // Response ready, randomly dropped during the back-pressure phase
    initial begin
        forever begin
            @(posedge clk_i);
            if (bp_en) begin
                rng_state = xorshift32(rng_state);
                dmi_resp_ready_i <= rng_state[7];
            end else begin
                dmi_resp_ready_i <= 1'b1;
            end
        end
    end

    // In-order response checker, sampled mid-cycle
    initial begin
        int idx;
        forever begin
            @(negedge clk_i);
            if (ndmreset_n && dmi_resp_valid_o && dmi_resp_ready_i) begin
                if (exp_q.size() == 0) begin
                    err_protocol++;
                    $display("A response arrived with no request outstanding");
                end else begin
                    idx = exp_q.pop_front();
                    check_value({tbl[idx].name, "_code"}, 32'(tbl[idx].exp_code),
                                32'(dmi_resp_code_o));
                    check_value({tbl[idx].name, "_data"}, tbl[idx].exp_data, dmi_resp_data_o);
                    check_value({tbl[idx].name, "_debug_req"}, 32'(tbl[idx].exp_dbg),
                                32'(debug_req_o));
                    check_value({tbl[idx].name, "_ndmreset"}, 32'(tbl[idx].exp_ndm),
                                32'(ndmreset_o));
                    received++;
                end
            end
        end
    end

    initial begin
        ndmreset_n       = 1'b0;
        dmi_req_valid_i  = 1'b0;
        dmi_req_addr_i   = '0;
        dmi_req_op_i     = DMI_NOP;
        dmi_req_data_i   = '0;
        dmi_resp_ready_i = 1'b1;
        bp_en            = 1'b0;
        abort            = 1'b0;
        received         = 0;
        err_value        = 0;
        err_timeout      = 0;
        err_protocol     = 0;
        rng_state        = 32'hd0a1_458c;
        build_table();
        compute_expected();

        repeat (3) @(posedge clk_i);
        ndmreset_n <= 1'b1;
        @(negedge clk_i);
        check_value("reset_req_ready", 32'd1, 32'(dmi_req_ready_o));
        check_value("reset_resp_valid", 32'd0, 32'(dmi_resp_valid_o));
        check_value("reset_debug_req", 32'd0, 32'(debug_req_o));
        check_value("reset_ndmreset", 32'd0, 32'(ndmreset_o));
        @(posedge clk_i);

        for (int i = 0; i < tbl.size() && !abort; i++) begin
            bp_en <= tbl[i].bp;
            exp_q.push_back(i);
            drive_request(i);
        end
        dmi_req_valid_i <= 1'b0;
        if (!abort) begin
            wait_responses();
        end
        finish_run();
    end

endmodule

//--- tests/dm_subsys_sva.sv
// ----------------------------------------------------------------------
// Bound assertions on the DMI handshakes, DMCONTROL gating and the
// reset state of the debug subsystem
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dm_subsys_sva
    import dm_pkg::*;
(
    input logic        clk_i,
    input logic        ndmreset_n,
    input logic        req_valid_i,
    input logic        req_ready_i,
    input logic        cmd_valid_i,
    input logic        resp_valid_i,
    input logic        resp_ready_i,
    input dmi_resp_e   resp_code_i,
    input logic [31:0] resp_data_i,
    input logic        debug_req_i,
    input logic        ndmreset_req_i,
    input dm_word_u    dmcontrol_i
);

    // Held response keeps its payload until accepted
    resp_stable: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        resp_valid_i && !resp_ready_i |=>
            resp_valid_i && $stable(resp_code_i) && $stable(resp_data_i))
        else $error("response payload changed while waiting for ready");

    // Empty capture entry fills only through a completed handshake
    req_accept: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        $rose(cmd_valid_i) |-> $past(req_valid_i && req_ready_i))
        else $error("request captured without ready");

    // Stored requests as well as the outputs need dmactive
    dbg_gated: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        (debug_req_i || ndmreset_req_i || dmcontrol_i.ctrl.haltreq ||
         dmcontrol_i.ctrl.ndmreset) |-> dmcontrol_i.ctrl.dmactive)
        else $error("debug request or ndmreset set while dmactive is low");

    reset_quiet: assert property (@(posedge clk_i) $rose(ndmreset_n) |=> !resp_valid_i)
        else $error("response valid right after reset release");

endmodule

bind dm_subsys_top dm_subsys_sva i_sva (
    .clk_i          ( clk_i             ),
    .ndmreset_n     ( ndmreset_n        ),
    .req_valid_i    ( dmi_req_valid_i   ),
    .req_ready_i    ( dmi_req_ready_o   ),
    .cmd_valid_i    ( cmd_valid         ),
    .resp_valid_i   ( dmi_resp_valid_o  ),
    .resp_ready_i   ( dmi_resp_ready_i  ),
    .resp_code_i    ( dmi_resp_code_o   ),
    .resp_data_i    ( dmi_resp_data_o   ),
    .debug_req_i    ( debug_req_o       ),
    .ndmreset_req_i ( ndmreset_o        ),
    .dmcontrol_i    ( i_dm_regs.rd_word )
);

//--- source/dm_subsys_top.sv
// ----------------------------------------------------------------------
// Debug subsystem top: request capture, debug registers, system
// SRAM and response buffer
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dm_subsys_top
    import dm_pkg::*;
#(
    parameter int unsigned NUM_WORDS = 256
) (
    input  logic                  clk_i,
    input  logic                  ndmreset_n,
    input  logic                  dmi_req_valid_i,
    output logic                  dmi_req_ready_o,
    input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
    input  dmi_op_e               dmi_req_op_i,
    input  logic [31:0]           dmi_req_data_i,
    output logic                  dmi_resp_valid_o,
    input  logic                  dmi_resp_ready_i,
    output dmi_resp_e             dmi_resp_code_o,
    output logic [31:0]           dmi_resp_data_o,
    output logic                  debug_req_o,
    output logic                  ndmreset_o
);

    logic                         cmd_valid;
    logic [DMI_ADDR_W-1:0]        cmd_addr;
    dmi_op_e                      cmd_op;
    logic [31:0]                  cmd_data;
    logic                         cmd_take;
    logic                         mem_req;
    logic                         mem_we;
    logic [$clog2(NUM_WORDS)-1:0] mem_addr;
    logic [31:0]                  mem_wdata;
    logic [31:0]                  mem_rdata;
    logic                         rsp_valid;
    dmi_resp_e                    rsp_code;
    logic [31:0]                  rsp_data;
    logic                         rsp_full;

    // ------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------
    dmi_req_capture i_req_capture (
        .clk_i       ( clk_i           ),
        .ndmreset_n  ( ndmreset_n      ),
        .req_valid_i ( dmi_req_valid_i ),
        .req_addr_i  ( dmi_req_addr_i  ),
        .req_op_i    ( dmi_req_op_i    ),
        .req_data_i  ( dmi_req_data_i  ),
        .cmd_take_i  ( cmd_take        ),
        .req_ready_o ( dmi_req_ready_o ),
        .cmd_valid_o ( cmd_valid       ),
        .cmd_addr_o  ( cmd_addr        ),
        .cmd_op_o    ( cmd_op          ),
        .cmd_data_o  ( cmd_data        )
    );

    // ------------------------------------------------------------------
    // Registers and system memory
    // ------------------------------------------------------------------
    dm_regs #(
        .NUM_WORDS ( NUM_WORDS )
    ) i_dm_regs (
        .clk_i       ( clk_i       ),
        .ndmreset_n  ( ndmreset_n  ),
        .cmd_valid_i ( cmd_valid   ),
        .cmd_addr_i  ( cmd_addr    ),
        .cmd_op_i    ( cmd_op      ),
        .cmd_data_i  ( cmd_data    ),
        .rsp_full_i  ( rsp_full    ),
        .mem_rdata_i ( mem_rdata   ),
        .cmd_take_o  ( cmd_take    ),
        .mem_req_o   ( mem_req     ),
        .mem_we_o    ( mem_we      ),
        .mem_addr_o  ( mem_addr    ),
        .mem_wdata_o ( mem_wdata   ),
        .rsp_valid_o ( rsp_valid   ),
        .rsp_code_o  ( rsp_code    ),
        .rsp_data_o  ( rsp_data    ),
        .debug_req_o ( debug_req_o ),
        .ndmreset_o  ( ndmreset_o  )
    );

    sys_sram #(
        .NUM_WORDS ( NUM_WORDS )
    ) i_sys_sram (
        .clk_i   ( clk_i     ),
        .req_i   ( mem_req   ),
        .we_i    ( mem_we    ),
        .addr_i  ( mem_addr  ),
        .wdata_i ( mem_wdata ),
        .rdata_o ( mem_rdata )
    );

    // ------------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------------
    dmi_resp_buffer i_resp_buffer (
        .clk_i        ( clk_i            ),
        .ndmreset_n   ( ndmreset_n       ),
        .rsp_valid_i  ( rsp_valid        ),
        .rsp_code_i   ( rsp_code         ),
        .rsp_data_i   ( rsp_data         ),
        .resp_ready_i ( dmi_resp_ready_i ),
        .rsp_full_o   ( rsp_full         ),
        .resp_valid_o ( dmi_resp_valid_o ),
        .resp_code_o  ( dmi_resp_code_o  ),
        .resp_data_o  ( dmi_resp_data_o  )
    );

endmodule

//--- source/dmi_resp_buffer.sv
// ----------------------------------------------------------------------
// One-entry DMI response register with the response handshake
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dmi_resp_buffer
    import dm_pkg::*;
(
    input  logic        clk_i,
    input  logic        ndmreset_n,
    input  logic        rsp_valid_i,
    input  dmi_resp_e   rsp_code_i,
    input  logic [31:0] rsp_data_i,
    input  logic        resp_ready_i,
    output logic        rsp_full_o,
    output logic        resp_valid_o,
    output dmi_resp_e   resp_code_o,
    output logic [31:0] resp_data_o
);

    logic full_q;

    // Space frees up in the same cycle the held response is accepted
    assign rsp_full_o   = full_q && !resp_ready_i;
    assign resp_valid_o = full_q;

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            full_q <= 1'b0;
        end else if (rsp_valid_i) begin
            full_q <= 1'b1;
        end else if (resp_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_valid_i) begin
            resp_code_o <= rsp_code_i;
            resp_data_o <= rsp_data_i;
        end
    end

endmodule

//--- source/sys_sram.sv
// ----------------------------------------------------------------------
// Single-port word SRAM, synchronous read
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module sys_sram #(
    parameter int unsigned NUM_WORDS = 256
) (
    input  logic                         clk_i,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  logic [31:0]                  wdata_i,
    output logic [31:0]                  rdata_o
);

    logic [31:0] mem_q [NUM_WORDS];
    logic [31:0] rdata_q;

    // Read returns the old word on a write access
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end
            rdata_q <= mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- source/dm_regs.sv
// ----------------------------------------------------------------------
// Debug register file: DATA0, DMCONTROL, SBADDRESS0 and the SBDATA0
// port with its system-bus access sequencer
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dm_regs
    import dm_pkg::*;
#(
    parameter int unsigned NUM_WORDS = 256
) (
    input  logic                         clk_i,
    input  logic                         ndmreset_n,
    input  logic                         cmd_valid_i,
    input  logic [DMI_ADDR_W-1:0]        cmd_addr_i,
    input  dmi_op_e                      cmd_op_i,
    input  logic [31:0]                  cmd_data_i,
    input  logic                         rsp_full_i,
    input  logic [31:0]                  mem_rdata_i,
    output logic                         cmd_take_o,
    output logic                         mem_req_o,
    output logic                         mem_we_o,
    output logic [$clog2(NUM_WORDS)-1:0] mem_addr_o,
    output logic [31:0]                  mem_wdata_o,
    output logic                         rsp_valid_o,
    output dmi_resp_e                    rsp_code_o,
    output logic [31:0]                  rsp_data_o,
    output logic                         debug_req_o,
    output logic                         ndmreset_o
);

    localparam int unsigned SB_AW = $clog2(NUM_WORDS);

    typedef enum logic {
        ST_IDLE,
        ST_MEM_WAIT
    } sb_state_e;

    sb_state_e        state_q, state_d;
    logic             sb_we_q, sb_we_d;
    logic [31:0]      data0_q, data0_d;
    logic [SB_AW-1:0] sbaddr_q, sbaddr_d;
    logic             haltreq_q, haltreq_d;
    logic             ndmreset_q, ndmreset_d;
    logic             dmactive_q, dmactive_d;
    logic             is_write;
    dm_word_u         wr_word;
    dm_word_u         rd_word;

    // DMCONTROL as seen on a read, reserved bits zero
    always_comb begin
        rd_word.raw           = '0;
        rd_word.ctrl.haltreq  = haltreq_q;
        rd_word.ctrl.ndmreset = ndmreset_q;
        rd_word.ctrl.dmactive = dmactive_q;
    end

    assign wr_word.raw = cmd_data_i;
    assign is_write    = (cmd_op_i == DMI_WRITE);

    // ------------------------------------------------------------------
    // Command decode and SBDATA0 sequencing
    // ------------------------------------------------------------------
    always_comb begin
        cmd_take_o  = 1'b0;
        mem_req_o   = 1'b0;
        mem_we_o    = 1'b0;
        mem_addr_o  = sbaddr_q;
        mem_wdata_o = cmd_data_i;
        rsp_valid_o = 1'b0;
        rsp_code_o  = DMI_SUCCESS;
        rsp_data_o  = '0;
        state_d     = state_q;
        sb_we_d     = sb_we_q;
        data0_d     = data0_q;
        sbaddr_d    = sbaddr_q;
        haltreq_d   = haltreq_q;
        ndmreset_d  = ndmreset_q;
        dmactive_d  = dmactive_q;

        case (state_q)
            ST_IDLE: begin
                if (cmd_valid_i && !rsp_full_i) begin
                    cmd_take_o  = 1'b1;
                    rsp_valid_o = 1'b1;
                    if (cmd_op_i == DMI_NOP) begin
                        rsp_code_o = DMI_SUCCESS;
                    end else if (cmd_op_i == DMI_READ || is_write) begin
                        case (cmd_addr_i)
                            ADDR_DATA0: begin
                                if (is_write) data0_d = cmd_data_i;
                                else rsp_data_o = data0_q;
                            end
                            ADDR_DMCONTROL: begin
                                if (is_write) begin
                                    if (!dmactive_q && !wr_word.ctrl.dmactive) begin
                                        // Inactive module only listens to dmactive
                                        dmactive_d = 1'b0;
                                    end else begin
                                        dmactive_d = wr_word.ctrl.dmactive;
                                        haltreq_d  = wr_word.ctrl.haltreq & wr_word.ctrl.dmactive;
                                        ndmreset_d = wr_word.ctrl.ndmreset & wr_word.ctrl.dmactive;
                                    end
                                end else begin
                                    rsp_data_o = rd_word.raw;
                                end
                            end
                            ADDR_SBADDRESS0: begin
                                if (is_write) sbaddr_d = cmd_data_i[SB_AW-1:0];
                                else rsp_data_o = {{(32-SB_AW){1'b0}}, sbaddr_q};
                            end
                            ADDR_SBDATA0: begin
                                // Response follows once the SRAM has answered
                                rsp_valid_o = 1'b0;
                                mem_req_o   = 1'b1;
                                mem_we_o    = is_write;
                                sb_we_d     = is_write;
                                state_d     = ST_MEM_WAIT;
                            end
                            default: rsp_code_o = DMI_FAILED;
                        endcase
                    end else begin
                        rsp_code_o = DMI_FAILED;
                    end
                end
            end
            ST_MEM_WAIT: begin
                // SRAM read data holds until the next request
                if (!rsp_full_i) begin
                    rsp_valid_o = 1'b1;
                    rsp_data_o  = sb_we_q ? 32'h0 : mem_rdata_i;
                    sbaddr_d    = sbaddr_q + 1'b1;
                    state_d     = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            state_q    <= ST_IDLE;
            sb_we_q    <= 1'b0;
            data0_q    <= '0;
            sbaddr_q   <= '0;
            haltreq_q  <= 1'b0;
            ndmreset_q <= 1'b0;
            dmactive_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            sb_we_q    <= sb_we_d;
            data0_q    <= data0_d;
            sbaddr_q   <= sbaddr_d;
            haltreq_q  <= haltreq_d;
            ndmreset_q <= ndmreset_d;
            dmactive_q <= dmactive_d;
        end
    end

    assign debug_req_o = haltreq_q & dmactive_q;
    assign ndmreset_o  = ndmreset_q & dmactive_q;

endmodule

//--- source/dmi_req_capture.sv
// ----------------------------------------------------------------------
// One-entry DMI request register with the request handshake
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dmi_req_capture
    import dm_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  ndmreset_n,
    input  logic                  req_valid_i,
    input  logic [DMI_ADDR_W-1:0] req_addr_i,
    input  dmi_op_e               req_op_i,
    input  logic [31:0]           req_data_i,
    input  logic                  cmd_take_i,
    output logic                  req_ready_o,
    output logic                  cmd_valid_o,
    output logic [DMI_ADDR_W-1:0] cmd_addr_o,
    output dmi_op_e               cmd_op_o,
    output logic [31:0]           cmd_data_o
);

    logic entry_valid_q;
    logic load;

    // Entry free, or emptied by the register block in this cycle
    assign req_ready_o = !entry_valid_q || cmd_take_i;
    assign load        = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            entry_valid_q <= 1'b0;
        end else if (load) begin
            entry_valid_q <= 1'b1;
        end else if (cmd_take_i) begin
            entry_valid_q <= 1'b0;
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (load) begin
            cmd_addr_o <= req_addr_i;
            cmd_op_o   <= req_op_i;
            cmd_data_o <= req_data_i;
        end
    end

    assign cmd_valid_o = entry_valid_q;

endmodule

//--- source/dm_pkg.sv
// ----------------------------------------------------------------------
// DMI op and result codes, debug register addresses and the
// DMCONTROL word layout shared by the debug subsystem
// ----------------------------------------------------------------------

package dm_pkg;

    // Width of the DMI register address, fixed by the protocol
    localparam int unsigned DMI_ADDR_W = 7;

    // Request op as carried on the DMI
    typedef enum logic [1:0] {
        DMI_NOP   = 2'h0,
        DMI_READ  = 2'h1,
        DMI_WRITE = 2'h2
    } dmi_op_e;

    // Response result code, 1 is reserved and 3 is busy (not used here)
    typedef enum logic [1:0] {
        DMI_SUCCESS = 2'h0,
        DMI_FAILED  = 2'h2
    } dmi_resp_e;

    // ------------------------------------------------------------------
    // Debug register map
    // ------------------------------------------------------------------
    localparam logic [DMI_ADDR_W-1:0] ADDR_DATA0      = 7'h04;
    localparam logic [DMI_ADDR_W-1:0] ADDR_DMCONTROL  = 7'h10;
    localparam logic [DMI_ADDR_W-1:0] ADDR_SBADDRESS0 = 7'h39;
    localparam logic [DMI_ADDR_W-1:0] ADDR_SBDATA0    = 7'h3C;

    // Subset of DMCONTROL, all other fields are reserved
    typedef struct packed {
        logic        haltreq;
        logic [28:0] reserved;
        logic        ndmreset;
        logic        dmactive;
    } dmcontrol_t;

    // One DMI data word, seen raw or as DMCONTROL
    typedef union packed {
        logic [31:0] raw;
        dmcontrol_t  ctrl;
    } dm_word_u;

endpackage
